//--- src/periph_defines.svh
// widths, address map and register offsets of the peripheral subsystem
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// apb bus
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32

`define GPIO_NUM 8  // pins on the gpio unit

// slave select field of paddr
`define SLV_SEL_MSB 15
`define SLV_SEL_LSB 12
`define SLV_GPIO    4'd0
`define SLV_TIMER   4'd1

// gpio register offsets, below the select field
`define GPIO_DIR        12'h000
`define GPIO_OUT        12'h004
`define GPIO_IN         12'h008  // read only, synced pins
`define GPIO_INT_EN     12'h00C
`define GPIO_INT_STATUS 12'h010  // write 1 to clear

// timer register offsets
`define TMR_CTRL  12'h000  // bit 0 enable, bit 1 clear on write
`define TMR_COUNT 12'h004  // read only
`define TMR_CMP   12'h008

`define FC_EVENT_W 32  // fabric controller event vector

`endif

//--- src/apb_pkg.sv
// apb request and response struct types
`include "periph_defines.svh"

package apb_pkg;

  // master to slave, one bundle per port
  typedef struct packed {
    logic [`PERIPH_ADDR_W-1:0] paddr;
    logic [`PERIPH_DATA_W-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  // slave to master
  typedef struct packed {
    logic [`PERIPH_DATA_W-1:0] prdata;
    logic                      pready;   // tied high, no wait states
    logic                      pslverr;
  } apb_rsp_t;

endpackage

//--- src/soc_event_pkg.sv
// gpio vector and fabric controller event struct types
`include "periph_defines.svh"

package soc_event_pkg;

  typedef logic [`GPIO_NUM-1:0] gpio_vec_t;  // one bit per pin

  // field order fixes the bit position of every event, msb first
  typedef struct packed {
    logic       err;           // 31 bus error
    gpio_vec_t  gpio_evt;      // 30:23
    logic [2:0] reserved_hi;   // 22:20
    logic       ref_fall;      // 19
    logic       ref_rise;      // 18
    logic [9:0] reserved_mid;  // 17:8
    logic       timer_lo;      // 7 timer match
    logic [6:0] sw_reserved;   // 6:0 kept for sw events
  } fc_event_t;

endpackage

//--- src/sync_wedge.sv
// two-stage synchronizer with per-bit rise and fall edge pulses
`timescale 1ns/100ps

module sync_wedge #(
  parameter type data_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  data_t serial_i,  // async levels
  output data_t serial_o,  // synced levels
  output data_t rise_o,    // one cycle per 0 -> 1
  output data_t fall_o     // one cycle per 1 -> 0
);

  data_t sync1_q;  // first stage, may go metastable
  data_t sync2_q;  // second stage, safe to use
  data_t hist_q;   // stage two one cycle ago

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      hist_q  <= '0;
    end else begin
      sync1_q <= serial_i;
      sync2_q <= sync1_q;
      hist_q  <= sync2_q;
    end
  end

  // edges from flops only, so the pulses are clean
  assign serial_o = sync2_q;
  assign rise_o   = sync2_q & ~hist_q;
  assign fall_o   = ~sync2_q & hist_q;

endmodule

//--- src/periph_bus_decoder.sv
// apb address decoder to gpio and timer slaves with error response and error event
`timescale 1ns/100ps
`include "periph_defines.svh"

module periph_bus_decoder (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  apb_pkg::apb_req_t apb_req_i,
  output apb_pkg::apb_rsp_t apb_rsp_o,
  output apb_pkg::apb_req_t gpio_req_o,
  input  apb_pkg::apb_rsp_t gpio_rsp_i,
  output apb_pkg::apb_req_t tmr_req_o,
  input  apb_pkg::apb_rsp_t tmr_rsp_i,
  output logic              err_evt_o
);

  logic [`SLV_SEL_MSB:`SLV_SEL_LSB] slv_sel;  // slave index field
  logic     hit_gpio;
  logic     hit_tmr;
  logic     unmapped;   // nobody lives here
  logic     err_q;

  assign slv_sel  = apb_req_i.paddr[`SLV_SEL_MSB:`SLV_SEL_LSB];
  assign hit_gpio = (slv_sel == `SLV_GPIO);
  assign hit_tmr  = (slv_sel == `SLV_TIMER);
  assign unmapped = ~hit_gpio & ~hit_tmr;

  //////////////////////////////////////////////////////////////////////
  // request fan out
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    gpio_req_o      = apb_req_i;
    gpio_req_o.psel = apb_req_i.psel & hit_gpio;  // only psel is gated
    tmr_req_o       = apb_req_i;
    tmr_req_o.psel  = apb_req_i.psel & hit_tmr;
  end

  // unmapped slot answers at once with slverr
  always_comb begin
    if (hit_gpio)     apb_rsp_o = gpio_rsp_i;
    else if (hit_tmr) apb_rsp_o = tmr_rsp_i;
    else              apb_rsp_o = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
  end

  // one error event pulse per unmapped access phase
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= apb_req_i.psel & apb_req_i.penable & unmapped;
    end
  end

  assign err_evt_o = err_q;

endmodule

//--- src/apb_gpio.sv
// apb gpio unit with direction, output, input sync and rising edge interrupt status
`timescale 1ns/100ps
`include "periph_defines.svh"

module apb_gpio (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  apb_pkg::apb_req_t        apb_req_i,
  output apb_pkg::apb_rsp_t        apb_rsp_o,
  input  soc_event_pkg::gpio_vec_t gpio_in_i,
  output soc_event_pkg::gpio_vec_t gpio_out_o,
  output soc_event_pkg::gpio_vec_t gpio_oe_o,
  output soc_event_pkg::gpio_vec_t gpio_evt_o
);

  import apb_pkg::*;
  import soc_event_pkg::*;

  logic [`SLV_SEL_LSB-1:0] reg_off;  // offset inside the slot
  logic      wr_en;
  gpio_vec_t wdata;
  gpio_vec_t dir_q;
  gpio_vec_t out_q;
  gpio_vec_t int_en_q;
  gpio_vec_t status_q;
  gpio_vec_t evt_q;
  gpio_vec_t in_sync;     // synced pin levels
  gpio_vec_t in_rise;     // synced rising edges
  gpio_vec_t rise_hit;    // edges on enabled pins
  gpio_vec_t clr_mask;    // w1c bits of this write
  gpio_vec_t rd_val;
  apb_rsp_t  rsp;

  assign reg_off = apb_req_i.paddr[`SLV_SEL_LSB-1:0];
  assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign wdata   = apb_req_i.pwdata[`GPIO_NUM-1:0];

  sync_wedge #(
    .data_t(gpio_vec_t)
  ) u_in_sync (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .serial_i(gpio_in_i),
    .serial_o(in_sync),
    .rise_o  (in_rise),
    .fall_o  ()           // falling edges raise nothing here
  );

  assign rise_hit = in_rise & int_en_q;
  assign clr_mask = (wr_en && reg_off == `GPIO_INT_STATUS) ? wdata : '0;

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      int_en_q <= '0;
      status_q <= '0;
      evt_q    <= '0;
    end else begin
      if (wr_en && reg_off == `GPIO_DIR)    dir_q    <= wdata;
      if (wr_en && reg_off == `GPIO_OUT)    out_q    <= wdata;
      if (wr_en && reg_off == `GPIO_INT_EN) int_en_q <= wdata;
      status_q <= (status_q & ~clr_mask) | rise_hit;  // set beats clear
      evt_q    <= rise_hit;                           // one cycle per edge
    end
  end

  // read mux, unknown offsets read 0
  always_comb begin
    rd_val = '0;
    case (reg_off)
      `GPIO_DIR:        rd_val = dir_q;
      `GPIO_OUT:        rd_val = out_q;
      `GPIO_IN:         rd_val = in_sync;
      `GPIO_INT_EN:     rd_val = int_en_q;
      `GPIO_INT_STATUS: rd_val = status_q;
      default:          rd_val = '0;
    endcase
  end

  assign rsp.prdata  = {{(`PERIPH_DATA_W-`GPIO_NUM){1'b0}}, rd_val};
  assign rsp.pready  = 1'b1;
  assign rsp.pslverr = 1'b0;
  assign apb_rsp_o   = rsp;

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;
  assign gpio_evt_o = evt_q;

endmodule

//--- src/apb_timer.sv
// apb timer counting reference ticks with compare, clear, stop and match event
`timescale 1ns/100ps
`include "periph_defines.svh"

module apb_timer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  apb_pkg::apb_req_t apb_req_i,
  output apb_pkg::apb_rsp_t apb_rsp_o,
  input  logic              tick_i,       // ref clock rise, one cycle
  input  logic              stoptimer_i,  // freeze, e.g. while halted
  output logic              evt_o
);

  import apb_pkg::*;

  logic [`SLV_SEL_LSB-1:0]   reg_off;
  logic                      wr_en;
  logic                      clr;       // ctrl write with bit 1 set
  logic                      tick_ok;   // tick that really counts
  logic                      en_q;
  logic [`PERIPH_DATA_W-1:0] count_q;
  logic [`PERIPH_DATA_W-1:0] cmp_q;
  logic                      evt_q;
  apb_rsp_t                  rsp;

  assign reg_off = apb_req_i.paddr[`SLV_SEL_LSB-1:0];
  assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign clr     = wr_en && (reg_off == `TMR_CTRL) && apb_req_i.pwdata[1];
  assign tick_ok = tick_i & en_q & ~stoptimer_i;

  //////////////////////////////////////////////////////////////////////
  // counter and compare
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
      evt_q   <= 1'b0;
    end else begin
      evt_q <= 1'b0;
      if (wr_en && reg_off == `TMR_CTRL) en_q  <= apb_req_i.pwdata[0];
      if (wr_en && reg_off == `TMR_CMP)  cmp_q <= apb_req_i.pwdata;
      if (clr) begin
        count_q <= '0;              // sw clear wins over a tick
      end else if (tick_ok) begin
        if (count_q == cmp_q) begin
          count_q <= '0;            // wrap, period is cmp+1 ticks
          evt_q   <= 1'b1;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  // read back, clear bit always reads 0
  always_comb begin
    rsp.prdata = '0;
    case (reg_off)
      `TMR_CTRL:  rsp.prdata = {{(`PERIPH_DATA_W-1){1'b0}}, en_q};
      `TMR_COUNT: rsp.prdata = count_q;
      `TMR_CMP:   rsp.prdata = cmp_q;
      default:    rsp.prdata = '0;
    endcase
    rsp.pready  = 1'b1;
    rsp.pslverr = 1'b0;
  end

  assign apb_rsp_o = rsp;
  assign evt_o     = evt_q;

endmodule

//--- src/soc_periph_top.sv
// peripheral subsystem top with decoder, gpio, timer, ref clock sync and event vector
`timescale 1ns/100ps

module soc_periph_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  apb_pkg::apb_req_t        apb_req_i,
  output apb_pkg::apb_rsp_t        apb_rsp_o,
  input  logic                     ref_clk_i,    // slow, async to clk_i
  input  logic                     stoptimer_i,
  input  soc_event_pkg::gpio_vec_t gpio_in_i,
  output soc_event_pkg::gpio_vec_t gpio_out_o,
  output soc_event_pkg::gpio_vec_t gpio_oe_o,
  output soc_event_pkg::fc_event_t fc_events_o
);

  import apb_pkg::*;
  import soc_event_pkg::*;

  apb_req_t  gpio_req;
  apb_rsp_t  gpio_rsp;
  apb_req_t  tmr_req;
  apb_rsp_t  tmr_rsp;
  logic      err_evt;
  gpio_vec_t gpio_evt;
  logic      timer_evt;
  logic      ref_rise;
  logic      ref_fall;
  fc_event_t events;

  //////////////////////////////////////////////////////////////////////
  // bus decode
  //////////////////////////////////////////////////////////////////////
  periph_bus_decoder u_decoder (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .gpio_req_o(gpio_req),
    .gpio_rsp_i(gpio_rsp),
    .tmr_req_o (tmr_req),
    .tmr_rsp_i (tmr_rsp),
    .err_evt_o (err_evt)
  );

  //////////////////////////////////////////////////////////////////////
  // slaves
  //////////////////////////////////////////////////////////////////////
  apb_gpio u_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .apb_req_i (gpio_req),
    .apb_rsp_o (gpio_rsp),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o),
    .gpio_evt_o(gpio_evt)
  );

  // ref clock edges into clk_i domain
  sync_wedge #(
    .data_t(logic)
  ) u_ref_sync (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .serial_i(ref_clk_i),
    .serial_o(),          // level not needed, edges only
    .rise_o  (ref_rise),
    .fall_o  (ref_fall)
  );

  apb_timer u_timer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .apb_req_i  (tmr_req),
    .apb_rsp_o  (tmr_rsp),
    .tick_i     (ref_rise),   // one count per ref rise
    .stoptimer_i(stoptimer_i),
    .evt_o      (timer_evt)
  );

  //////////////////////////////////////////////////////////////////////
  // fc event routing
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    events              = '0;  // reserved fields stay 0
    events.err          = err_evt;
    events.gpio_evt     = gpio_evt;
    events.ref_fall     = ref_fall;
    events.ref_rise     = ref_rise;
    events.timer_lo     = timer_evt;
  end

  assign fc_events_o = events;

endmodule

//--- verif/tb_clock_gen.sv
// testbench clock of 4 ns period and power-on reset held for two cycles
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 2 ns half period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // released away from the rising edge
  end

endmodule

//--- verif/soc_periph_properties.sv
// concurrent assertions on the decoder apb port and the bus error event
`timescale 1ns/100ps

module soc_periph_properties (
  input logic              clk_i,
  input logic              rst_n_i,
  input apb_pkg::apb_req_t apb_req_i,
  input apb_pkg::apb_rsp_t apb_rsp_o,
  input logic              err_evt_o
);

  int unsigned fail_cnt = 0;  // read by the testbench top

  // zero wait states
  a_pready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_o.pready)
    else begin
      fail_cnt++;
      $error("pready low in an apb access phase");
    end

  // error event is a single cycle pulse
  a_err_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_evt_o |=> !err_evt_o)
    else begin
      fail_cnt++;
      $error("err_evt_o high for two cycles in a row");
    end

  a_rsp_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (apb_req_i.psel && apb_req_i.penable) |-> !$isunknown(apb_rsp_o))
    else begin
      fail_cnt++;
      $error("apb response has x bits in an access phase");
    end

endmodule

//--- verif/soc_periph_checker.sv
// monitor comparing apb responses, pin outputs and event pulse counts
`timescale 1ns/100ps
`include "periph_defines.svh"

module soc_periph_checker (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input apb_pkg::apb_req_t        apb_req_i,
  input apb_pkg::apb_rsp_t        apb_rsp_i,
  input soc_event_pkg::gpio_vec_t gpio_out_i,
  input soc_event_pkg::gpio_vec_t gpio_oe_i,
  input soc_event_pkg::fc_event_t fc_events_i
);

  import soc_event_pkg::*;

  // one expected response per access, queued by the stimulus
  typedef struct packed {
    logic                      is_rd;
    logic                      err;
    logic [`PERIPH_DATA_W-1:0] data;
  } exp_rsp_t;

  exp_rsp_t    exp_q[$];
  string       cur_test;
  int unsigned fail_cnt   = 0;
  int unsigned test_fail  = 0;
  int unsigned tests_run  = 0;
  int unsigned tests_ok   = 0;
  int unsigned cnt_err    = 0;
  int unsigned cnt_gpio   = 0;
  int unsigned cnt_rise   = 0;
  int unsigned cnt_fall   = 0;
  int unsigned cnt_tmr    = 0;

  task automatic flag(input string msg);
    fail_cnt++;
    test_fail++;
    $display("[FAIL] %0t ns %s: %s", $time, cur_test, msg);
  endtask

  task automatic push_exp(input logic is_rd, input logic [31:0] data, input logic err);
    exp_q.push_back('{is_rd: is_rd, err: err, data: data});
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_fail = 0;
    cnt_err   = 0;
    cnt_gpio  = 0;
    cnt_rise  = 0;
    cnt_fall  = 0;
    cnt_tmr   = 0;
  endtask

  task automatic check_pins(input gpio_vec_t exp_oe, input gpio_vec_t exp_out);
    if (gpio_oe_i !== exp_oe)
      flag($sformatf("gpio_oe_o 0x%02h exp 0x%02h", gpio_oe_i, exp_oe));
    if (gpio_out_i !== exp_out)
      flag($sformatf("gpio_out_o 0x%02h exp 0x%02h", gpio_out_i, exp_out));
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) flag($sformatf("%s pulses %0d exp %0d", what, got, exp));
  endtask

  task automatic finish_test(input int e_err, input int e_gpio, input int e_rise,
                             input int e_fall, input int e_tmr);
    check_count("err", cnt_err, e_err);
    check_count("gpio_evt", cnt_gpio, e_gpio);
    check_count("ref_rise", cnt_rise, e_rise);
    check_count("ref_fall", cnt_fall, e_fall);
    check_count("timer", cnt_tmr, e_tmr);
    tests_run++;
    if (test_fail == 0) begin
      tests_ok++;
      $display("test %-12s ok", cur_test);
    end else begin
      $display("test %-12s %0d check(s) failed", cur_test, test_fail);
    end
  endtask

  task automatic report();
    $display("summary: %0d tests, %0d passed, %0d failed checks, %0d responses left",
             tests_run, tests_ok, fail_cnt, exp_q.size());
  endtask

  //////////////////////////////////////////////////////////////////////
  // per-cycle monitor
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin
    exp_rsp_t e;
    if (rst_n_i) begin
      cnt_err  += fc_events_i.err;
      cnt_gpio += $countones(fc_events_i.gpio_evt);
      cnt_rise += fc_events_i.ref_rise;
      cnt_fall += fc_events_i.ref_fall;
      cnt_tmr  += fc_events_i.timer_lo;
      if ({fc_events_i.reserved_hi, fc_events_i.reserved_mid, fc_events_i.sw_reserved} !== '0)
        flag("reserved event bits not 0");
      if (apb_req_i.psel && apb_req_i.penable) begin  // access phase
        if (exp_q.size() == 0) begin
          fail_cnt++;
          test_fail++;
          $display("error: apb access at 0x%08h with no expected response", apb_req_i.paddr);
        end else begin
          e = exp_q.pop_front();
          if (apb_rsp_i.pslverr !== e.err)
            flag($sformatf("addr 0x%08h pslverr %b exp %b", apb_req_i.paddr,
                           apb_rsp_i.pslverr, e.err));
          if (e.is_rd && apb_rsp_i.prdata !== e.data)
            flag($sformatf("read 0x%08h got 0x%08h exp 0x%08h", apb_req_i.paddr,
                           apb_rsp_i.prdata, e.data));
        end
      end
    end
  end

endmodule

//--- verif/tb_soc_periph.sv
// testbench top with dut, lfsr stimulus, reference model and test sequence
`timescale 1ns/100ps
`include "periph_defines.svh"

module tb_soc_periph;

  import apb_pkg::*;
  import soc_event_pkg::*;

  localparam logic [31:0] gpio_base = 32'h0000_0000;
  localparam logic [31:0] tmr_base  = 32'h0000_1000;
  localparam int acc_cyc   = 3;   // setup, access, idle
  localparam int half_cyc  = 6;   // ref clock half period in clk cycles
  localparam int settle    = 4;   // covers sync and event latency
  localparam int n_rw      = 4;
  localparam int n_pins    = 6;
  localparam int n_ticks   = 13;
  localparam int n_stopped = 5;
  // cycle budget per test
  localparam int t1_cyc = n_rw * (4 * acc_cyc) + settle;
  localparam int t2_cyc = 2 * acc_cyc + settle;
  localparam int t3_cyc = acc_cyc + n_pins * (1 + settle + 2 * acc_cyc) + 2 * acc_cyc + settle;
  localparam int t4_cyc = 3 * acc_cyc + n_ticks * (2 * half_cyc + 1) + acc_cyc + settle;
  localparam int t5_cyc = 2 + n_stopped * (2 * half_cyc + 1) + 4 * acc_cyc + settle;
  localparam int timeout_cyc = t1_cyc + t2_cyc + t3_cyc + t4_cyc + t5_cyc + 100;

  logic      clk;
  logic      rst_n;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  logic      ref_clk;
  logic      stoptimer;
  gpio_vec_t gpio_in;
  gpio_vec_t gpio_out;
  gpio_vec_t gpio_oe;
  fc_event_t fc_events;

  logic [31:0] lfsr_q;
  int unsigned cycle_cnt = 0;
  // reference model state
  gpio_vec_t   m_dir, m_out, m_in, m_int_en, m_status;
  logic        m_en;
  logic [31:0] m_count, m_cmp;
  int          exp_err, exp_gpio, exp_rise, exp_fall, exp_tmr;

  tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  soc_periph_top u_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .ref_clk_i  (ref_clk),
    .stoptimer_i(stoptimer),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_oe_o  (gpio_oe),
    .fc_events_o(fc_events)
  );

  soc_periph_checker u_chk (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .apb_req_i  (apb_req),
    .apb_rsp_i  (apb_rsp),
    .gpio_out_i (gpio_out),
    .gpio_oe_i  (gpio_oe),
    .fc_events_i(fc_events)
  );

  bind periph_bus_decoder soc_periph_properties u_props (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .apb_req_i(apb_req_i),
    .apb_rsp_o(apb_rsp_o),
    .err_evt_o(err_evt_o)
  );

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // expected {pslverr, prdata} of a read at addr
  function automatic logic [32:0] ref_read(logic [31:0] addr);
    logic [31:0] d;
    d = '0;
    if (addr[`SLV_SEL_MSB:`SLV_SEL_LSB] == `SLV_GPIO) begin
      case (addr[`SLV_SEL_LSB-1:0])
        `GPIO_DIR:        d = m_dir;
        `GPIO_OUT:        d = m_out;
        `GPIO_IN:         d = m_in;
        `GPIO_INT_EN:     d = m_int_en;
        `GPIO_INT_STATUS: d = m_status;
        default:          d = '0;
      endcase
      return {1'b0, d};
    end
    if (addr[`SLV_SEL_MSB:`SLV_SEL_LSB] == `SLV_TIMER) begin
      case (addr[`SLV_SEL_LSB-1:0])
        `TMR_CTRL:  d = {31'b0, m_en};  // clear bit reads 0
        `TMR_COUNT: d = m_count;
        `TMR_CMP:   d = m_cmp;
        default:    d = '0;
      endcase
      return {1'b0, d};
    end
    return {1'b1, 32'h0};  // unmapped slot
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] d);
    if (addr[`SLV_SEL_MSB:`SLV_SEL_LSB] == `SLV_GPIO) begin
      case (addr[`SLV_SEL_LSB-1:0])
        `GPIO_DIR:        m_dir    = d[`GPIO_NUM-1:0];
        `GPIO_OUT:        m_out    = d[`GPIO_NUM-1:0];
        `GPIO_INT_EN:     m_int_en = d[`GPIO_NUM-1:0];
        `GPIO_INT_STATUS: m_status = m_status & ~d[`GPIO_NUM-1:0];
        default: ;
      endcase
    end else if (addr[`SLV_SEL_MSB:`SLV_SEL_LSB] == `SLV_TIMER) begin
      if (addr[`SLV_SEL_LSB-1:0] == `TMR_CTRL) begin
        m_en = d[0];
        if (d[1]) m_count = '0;
      end
      if (addr[`SLV_SEL_LSB-1:0] == `TMR_CMP) m_cmp = d;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks driving on the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
    logic [32:0] exp;
    exp = ref_read(addr);
    u_chk.push_exp(!wr, exp[31:0], exp[32]);
    @(negedge clk);
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.pwrite  = wr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;  // access phase without wait states
    @(negedge clk);
    apb_req = '0;
    if (wr) model_write(addr, wdata);
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
    apb_access(1'b1, addr, wdata);
  endtask

  task automatic apb_read(input logic [31:0] addr);
    apb_access(1'b0, addr, 32'h0);
  endtask

  // one slow ref clock period
  task automatic ref_period();
    @(negedge clk);
    ref_clk = 1'b1;
    exp_rise++;
    if (m_en && !stoptimer) begin
      if (m_count == m_cmp) begin
        m_count = '0;
        exp_tmr++;
      end else begin
        m_count++;
      end
    end
    repeat (half_cyc) @(negedge clk);
    ref_clk = 1'b0;
    exp_fall++;
    repeat (half_cyc) @(negedge clk);
  endtask

  task automatic drive_pins(input gpio_vec_t lvl);
    gpio_vec_t hit;
    hit = lvl & ~m_in & m_int_en;  // enabled rising edges
    @(negedge clk);
    gpio_in  = lvl;
    m_in     = lvl;
    m_status = m_status | hit;
    exp_gpio += $countones(hit);
    repeat (settle) @(negedge clk);
  endtask

  task automatic begin_test(input string name);
    exp_err  = 0;
    exp_gpio = 0;
    exp_rise = 0;
    exp_fall = 0;
    exp_tmr  = 0;
    u_chk.start_test(name);
  endtask

  task automatic end_test();
    repeat (settle) @(negedge clk);
    u_chk.finish_test(exp_err, exp_gpio, exp_rise, exp_fall, exp_tmr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    apb_req   = '0;
    ref_clk   = 1'b0;
    stoptimer = 1'b0;
    gpio_in   = '0;
    lfsr_q    = 32'h3230;
    m_dir     = '0;
    m_out     = '0;
    m_in      = '0;
    m_int_en  = '0;
    m_status  = '0;
    m_en      = 1'b0;
    m_count   = '0;
    m_cmp     = '0;
    @(posedge rst_n);

    begin_test("gpio_rw");
    for (int i = 0; i < n_rw; i++) begin
      apb_write(gpio_base + `GPIO_DIR, rand_bits(`GPIO_NUM));
      apb_write(gpio_base + `GPIO_OUT, rand_bits(`GPIO_NUM));
      u_chk.check_pins(m_dir, m_out);
      apb_read(gpio_base + `GPIO_DIR);
      apb_read(gpio_base + `GPIO_OUT);
    end
    end_test();

    begin_test("bus_error");
    apb_read(32'h0000_5000);
    exp_err++;
    apb_write(32'h0000_F00C, 32'hDEAD_BEEF);
    exp_err++;
    end_test();

    begin_test("gpio_irq");
    apb_write(gpio_base + `GPIO_INT_EN, rand_bits(`GPIO_NUM));
    for (int i = 0; i < n_pins; i++) begin
      drive_pins(rand_bits(`GPIO_NUM));
      apb_read(gpio_base + `GPIO_IN);
      apb_read(gpio_base + `GPIO_INT_STATUS);
    end
    apb_write(gpio_base + `GPIO_INT_STATUS, rand_bits(`GPIO_NUM));
    apb_read(gpio_base + `GPIO_INT_STATUS);
    end_test();

    begin_test("timer_run");
    apb_write(tmr_base + `TMR_CMP, 32'd2 + rand_bits(2));  // period 3 to 6 ticks
    apb_write(tmr_base + `TMR_CTRL, 32'h3);                // enable and clear
    apb_read(tmr_base + `TMR_CMP);
    for (int i = 0; i < n_ticks; i++) ref_period();
    apb_read(tmr_base + `TMR_COUNT);
    end_test();

    begin_test("timer_stop");
    @(negedge clk);
    stoptimer = 1'b1;
    for (int i = 0; i < n_stopped; i++) ref_period();
    apb_read(tmr_base + `TMR_COUNT);
    @(negedge clk);
    stoptimer = 1'b0;
    apb_write(tmr_base + `TMR_CTRL, 32'h3);
    apb_read(tmr_base + `TMR_COUNT);
    apb_read(tmr_base + `TMR_CTRL);
    end_test();

    u_chk.report();
    if (u_chk.fail_cnt == 0 && u_dut.u_decoder.u_props.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // run limit from the summed test budgets
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cyc) begin
      $display("timeout: tests still running after %0d clock cycles", timeout_cyc);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+src
src/apb_pkg.sv
src/soc_event_pkg.sv
src/sync_wedge.sv
src/periph_bus_decoder.sv
src/apb_gpio.sv
src/apb_timer.sv
src/soc_periph_top.sv
verif/tb_clock_gen.sv
verif/soc_periph_properties.sv
verif/soc_periph_checker.sv
verif/tb_soc_periph.sv
